// File: dv/commit_input.txt
# lane0: v pc inst wen wnum wdata excp ertn ecode, lane1: same nine fields
# then expected slot excp_valid excp_pc excp_inst excp_ecode, all hex
1 100 a0 1 3 11 0 0 0 1 104 b0 1 4 22 0 0 0 0 0 104 b0 0
1 108 a1 1 5 33 0 0 0 1 104 b1 0 0 0 0 0 0 1 0 108 a1 0
1 200 a2 0 0 0 1 0 5 1 200 b2 1 6 44 0 0 0 1 1 200 a2 5
1 300 a3 1 1f ffffffff 0 0 0 0 0 0 0 0 0 0 0 0 0 0 300 a3 0
0 0 0 0 0 0 0 0 0 1 400 b4 1 7 55 0 0 0 1 0 400 b4 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 500 a5 0 0 0 1 0 8 1 504 b5 0 0 0 1 0 9 0 1 500 a5 8
1 600 a6 1 2 66 0 0 0 1 604 b6 0 0 0 1 0 c 0 1 604 b6 c
1 704 a7 0 0 0 1 0 e 1 700 b7 0 0 0 1 0 d 1 1 700 b7 d
1 804 a8 0 0 0 1 0 3f 1 800 b8 1 8 77 0 0 0 1 1 804 a8 3f
1 900 a9 0 0 0 0 1 0 1 904 b9 1 9 88 0 0 0 0 0 904 b9 0
1 fffffffc aa 1 a 99 0 0 0 1 0 ba 1 b aa 0 0 0 1 0 fffffffc aa 0
0 0 0 0 0 0 0 0 0 1 a00 bb 0 0 0 1 0 2 1 1 a00 bb 2
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0
1 b00 ac 0 0 0 1 0 1 0 0 0 0 0 0 0 0 0 0 1 b00 ac 1
1 c00 ad 1 c bb 0 0 0 1 c00 bd 0 0 0 1 0 4 1 1 c00 bd 4
1 1 ae 1 d cc 0 0 0 1 2 be 1 e dd 0 0 0 0 0 2 be 0
1 80000000 af 0 0 0 0 0 0 1 7ffffffc bf 0 0 0 0 0 0 1 0 80000000 af 0

// File: dv/tb_commit_trace.sv
`timescale 1ns/1ps

module tb_commit_trace;

    localparam int COUNT_W   = 64;
    localparam int MAX_LINES = 64;
    localparam int NUM_COLS  = 23;
    localparam int RAND_CYC  = 40;

    logic                 aclk = 1'b0;
    logic                 rst;

    logic                 cmt_valid_0_i, cmt_wen_0_i, cmt_excp_0_i, cmt_ertn_0_i;
    commit_pkg::addr_t    cmt_pc_0_i;
    commit_pkg::inst_t    cmt_inst_0_i;
    commit_pkg::reg_num_t cmt_wnum_0_i;
    commit_pkg::data_t    cmt_wdata_0_i;
    commit_pkg::ecode_t   cmt_ecode_0_i;
    logic                 cmt_valid_1_i, cmt_wen_1_i, cmt_excp_1_i, cmt_ertn_1_i;
    commit_pkg::addr_t    cmt_pc_1_i;
    commit_pkg::inst_t    cmt_inst_1_i;
    commit_pkg::reg_num_t cmt_wnum_1_i;
    commit_pkg::data_t    cmt_wdata_1_i;
    commit_pkg::ecode_t   cmt_ecode_1_i;

    logic                 trace_valid_0_o, trace_wen_0_o, trace_valid_1_o, trace_wen_1_o;
    commit_pkg::addr_t    trace_pc_0_o, trace_pc_1_o, excp_pc_o;
    commit_pkg::inst_t    trace_inst_0_o, trace_inst_1_o, excp_inst_o;
    commit_pkg::reg_num_t trace_wnum_0_o, trace_wnum_1_o;
    commit_pkg::data_t    trace_wdata_0_o, trace_wdata_1_o;
    logic                 slot_o, excp_valid_o, ertn_o;
    commit_pkg::ecode_t   excp_ecode_o;
    logic [COUNT_W-1:0]   cycle_cnt_o, instr_cnt_o;

    // model of the registered stage one cycle behind the drive
    logic                 m_v [commit_pkg::NUM_LANES];
    logic                 m_wen [commit_pkg::NUM_LANES];
    logic                 m_ex [commit_pkg::NUM_LANES];
    commit_pkg::addr_t    m_pc [commit_pkg::NUM_LANES];
    commit_pkg::inst_t    m_inst [commit_pkg::NUM_LANES];
    commit_pkg::reg_num_t m_wnum [commit_pkg::NUM_LANES];
    commit_pkg::data_t    m_wdata [commit_pkg::NUM_LANES];
    commit_pkg::ecode_t   m_ec [commit_pkg::NUM_LANES];
    logic                 m_ertn0;
    logic [COUNT_W-1:0]   exp_cycle, exp_instr;

    logic [31:0] vecs [0:MAX_LINES-1][0:NUM_COLS-1];
    int          n_lines = 0;
    logic        loaded = 1'b0;
    int          seed = 90194;

    commit_trace_top #(.COUNT_W(COUNT_W)) dut0 (.*);

    always #50 aclk = ~aclk;

    task automatic fail_now();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_bit(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_addr(string what, commit_pkg::addr_t got, commit_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_inst(string what, commit_pkg::inst_t got, commit_pkg::inst_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_data(string what, commit_pkg::data_t got, commit_pkg::data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_reg_num(string what, commit_pkg::reg_num_t got,
                                 commit_pkg::reg_num_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_ecode(string what, commit_pkg::ecode_t got, commit_pkg::ecode_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
            fail_now();
        end
    endtask

    task automatic check_count(string what, logic [COUNT_W-1:0] got,
                               logic [COUNT_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
            fail_now();
        end
    endtask

    // lane 0 position among valid lanes
    function automatic logic slot_rule(logic v0, logic v1, commit_pkg::addr_t pc0,
                                       commit_pkg::addr_t pc1);
        if (v0 && v1) begin
            return (pc0 < pc1) ? 1'b0 : 1'b1;
        end
        return v1 && !v0;
    endfunction

    // older lane wins if it trapped
    function automatic int excp_lane(commit_pkg::addr_t pc0, commit_pkg::addr_t pc1,
                                     logic ex0, logic ex1);
        int   older;
        logic older_ex;
        older    = (pc0 < pc1) ? 0 : 1;
        older_ex = (older == 0) ? ex0 : ex1;
        if (older_ex) begin
            return older;
        end
        return 1 - older;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f [0:NUM_COLS-1];
        fd = $fopen("dv/commit_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/commit_input.txt");
            fail_now();
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                code = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                    f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                    f[22]);
                if (code == NUM_COLS && n_lines < MAX_LINES) begin
                    for (int k = 0; k < NUM_COLS; k++) begin
                        vecs[n_lines][k] = f[k];
                    end
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    // model update and compare for one clock, returns at edge + 2 ns
    task automatic step_and_check(logic from_file, int idx);
        int   lane;
        logic e_slot;
        @(posedge aclk);
        #1;
        exp_cycle = exp_cycle + COUNT_W'(1);
        exp_instr = exp_instr + COUNT_W'(m_v[0]) + COUNT_W'(m_v[1]);
        m_v[0] = cmt_valid_0_i;
        m_v[1] = cmt_valid_1_i;
        m_wen[0] = cmt_wen_0_i;
        m_wen[1] = cmt_wen_1_i;
        m_ex[0] = cmt_excp_0_i;
        m_ex[1] = cmt_excp_1_i;
        m_pc[0] = cmt_pc_0_i;
        m_pc[1] = cmt_pc_1_i;
        m_inst[0] = cmt_inst_0_i;
        m_inst[1] = cmt_inst_1_i;
        m_wnum[0] = cmt_wnum_0_i;
        m_wnum[1] = cmt_wnum_1_i;
        m_wdata[0] = cmt_wdata_0_i;
        m_wdata[1] = cmt_wdata_1_i;
        m_ec[0] = cmt_ecode_0_i;
        m_ec[1] = cmt_ecode_1_i;
        m_ertn0 = cmt_ertn_0_i;

        check_bit("trace_valid_0", trace_valid_0_o, m_v[0]);
        check_bit("trace_valid_1", trace_valid_1_o, m_v[1]);
        check_bit("trace_wen_0", trace_wen_0_o, m_wen[0]);
        check_bit("trace_wen_1", trace_wen_1_o, m_wen[1]);
        check_addr("trace_pc_0", trace_pc_0_o, m_pc[0]);
        check_addr("trace_pc_1", trace_pc_1_o, m_pc[1]);
        check_inst("trace_inst_0", trace_inst_0_o, m_inst[0]);
        check_inst("trace_inst_1", trace_inst_1_o, m_inst[1]);
        check_reg_num("trace_wnum_0", trace_wnum_0_o, m_wnum[0]);
        check_reg_num("trace_wnum_1", trace_wnum_1_o, m_wnum[1]);
        check_data("trace_wdata_0", trace_wdata_0_o, m_wdata[0]);
        check_data("trace_wdata_1", trace_wdata_1_o, m_wdata[1]);
        check_bit("ertn", ertn_o, m_ertn0);
        check_count("cycle_cnt", cycle_cnt_o, exp_cycle);
        check_count("instr_cnt", instr_cnt_o, exp_instr);

        if (from_file) begin
            check_bit("slot (file)", slot_o, vecs[idx][18][0]);
            check_bit("excp_valid (file)", excp_valid_o, vecs[idx][19][0]);
            check_addr("excp_pc (file)", excp_pc_o, vecs[idx][20]);
            check_inst("excp_inst (file)", excp_inst_o, vecs[idx][21]);
            check_ecode("excp_ecode (file)", excp_ecode_o, vecs[idx][22][5:0]);
        end else begin
            e_slot = slot_rule(m_v[0], m_v[1], m_pc[0], m_pc[1]);
            lane = excp_lane(m_pc[0], m_pc[1], m_ex[0], m_ex[1]);
            check_bit("slot", slot_o, e_slot);
            check_bit("excp_valid", excp_valid_o, m_ex[lane]);
            check_addr("excp_pc", excp_pc_o, m_pc[lane]);
            check_inst("excp_inst", excp_inst_o, m_inst[lane]);
            check_ecode("excp_ecode", excp_ecode_o, m_ec[lane]);
        end
        #1;
    endtask

    task automatic drive_line(int i);
        cmt_valid_0_i = vecs[i][0][0];
        cmt_pc_0_i    = vecs[i][1];
        cmt_inst_0_i  = vecs[i][2];
        cmt_wen_0_i   = vecs[i][3][0];
        cmt_wnum_0_i  = vecs[i][4][4:0];
        cmt_wdata_0_i = vecs[i][5];
        cmt_excp_0_i  = vecs[i][6][0];
        cmt_ertn_0_i  = vecs[i][7][0];
        cmt_ecode_0_i = vecs[i][8][5:0];
        cmt_valid_1_i = vecs[i][9][0];
        cmt_pc_1_i    = vecs[i][10];
        cmt_inst_1_i  = vecs[i][11];
        cmt_wen_1_i   = vecs[i][12][0];
        cmt_wnum_1_i  = vecs[i][13][4:0];
        cmt_wdata_1_i = vecs[i][14];
        cmt_excp_1_i  = vecs[i][15][0];
        cmt_ertn_1_i  = vecs[i][16][0];
        cmt_ecode_1_i = vecs[i][17][5:0];
    endtask

    task automatic drive_random();
        logic [31:0] r;
        r = $random(seed);
        cmt_valid_0_i = r[0];
        cmt_valid_1_i = r[1];
        cmt_wen_0_i   = r[2] & r[0]; // no write without a commit
        cmt_wen_1_i   = r[3] & r[1];
        cmt_excp_0_i  = r[4];
        cmt_excp_1_i  = r[5];
        cmt_ertn_0_i  = r[6];
        cmt_ertn_1_i  = r[7];
        cmt_wnum_0_i  = r[12:8];
        cmt_wnum_1_i  = r[17:13];
        cmt_ecode_0_i = r[23:18];
        cmt_ecode_1_i = r[29:24];
        cmt_pc_0_i    = $random(seed);
        cmt_pc_1_i    = r[30] ? cmt_pc_0_i : $random(seed); // equal pcs now and then
        cmt_inst_0_i  = $random(seed);
        cmt_inst_1_i  = $random(seed);
        cmt_wdata_0_i = $random(seed);
        cmt_wdata_1_i = $random(seed);
    endtask

    initial begin
        int wd_ns;
        wait (loaded);
        wd_ns = 100 * (8 + n_lines + RAND_CYC + 20);
        #(wd_ns);
        $display("simulation did not finish within %0d ns", wd_ns);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst = 1'b1;
        // both lanes busy during reset so the clear shows on the outputs
        {cmt_valid_0_i, cmt_wen_0_i, cmt_excp_0_i, cmt_ertn_0_i} = '1;
        {cmt_valid_1_i, cmt_wen_1_i, cmt_excp_1_i, cmt_ertn_1_i} = '1;
        {cmt_pc_0_i, cmt_inst_0_i, cmt_wnum_0_i, cmt_wdata_0_i, cmt_ecode_0_i} = '0;
        {cmt_pc_1_i, cmt_inst_1_i, cmt_wnum_1_i, cmt_wdata_1_i, cmt_ecode_1_i} = '0;
        for (int l = 0; l < commit_pkg::NUM_LANES; l++) begin
            {m_v[l], m_wen[l], m_ex[l]} = '0;
            {m_pc[l], m_inst[l], m_wnum[l], m_wdata[l], m_ec[l]} = '0;
        end
        m_ertn0   = 1'b0;
        exp_cycle = '0;
        exp_instr = '0;
        load_vectors();
        loaded = 1'b1;

        repeat (8) @(posedge aclk);
        #2;
        rst = 1'b0;
        // outputs right after reset
        check_bit("valid_0 after reset", trace_valid_0_o, 1'b0);
        check_bit("valid_1 after reset", trace_valid_1_o, 1'b0);
        check_bit("wen_0 after reset", trace_wen_0_o, 1'b0);
        check_bit("wen_1 after reset", trace_wen_1_o, 1'b0);
        check_bit("excp_valid after reset", excp_valid_o, 1'b0);
        check_bit("ertn after reset", ertn_o, 1'b0);
        check_count("cycle_cnt after reset", cycle_cnt_o, '0);
        check_count("instr_cnt after reset", instr_cnt_o, '0);

        for (int i = 0; i < n_lines; i++) begin
            drive_line(i);
            step_and_check(1'b1, i);
        end
        for (int i = 0; i < RAND_CYC; i++) begin
            drive_random();
            step_and_check(1'b0, 0);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: files.f
verilog/commit_pkg.sv
verilog/commit_capture.sv
verilog/commit_order.sv
verilog/event_counters.sv
verilog/commit_trace_top.sv
dv/tb_commit_trace.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the commit tracer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_commit_trace \
    -Mdir obj_dir \
    -f files.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_commit_trace > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    exit 1
fi

echo "simulation passed"
exit 0

// File: verilog/commit_capture.sv
`timescale 1ns/1ps

module commit_capture (
    input  logic                 aclk,
    input  logic                 rst,

    // lane 0 from writeback
    input  logic                 cmt_valid_0_i,
    input  commit_pkg::addr_t    cmt_pc_0_i,
    input  commit_pkg::inst_t    cmt_inst_0_i,
    input  logic                 cmt_wen_0_i,
    input  commit_pkg::reg_num_t cmt_wnum_0_i,
    input  commit_pkg::data_t    cmt_wdata_0_i,
    input  logic                 cmt_excp_0_i,
    input  logic                 cmt_ertn_0_i,
    input  commit_pkg::ecode_t   cmt_ecode_0_i,

    // lane 1 from writeback
    input  logic                 cmt_valid_1_i,
    input  commit_pkg::addr_t    cmt_pc_1_i,
    input  commit_pkg::inst_t    cmt_inst_1_i,
    input  logic                 cmt_wen_1_i,
    input  commit_pkg::reg_num_t cmt_wnum_1_i,
    input  commit_pkg::data_t    cmt_wdata_1_i,
    input  logic                 cmt_excp_1_i,
    input  logic                 cmt_ertn_1_i,
    input  commit_pkg::ecode_t   cmt_ecode_1_i,

    output logic                 reg_valid_0_o,
    output commit_pkg::addr_t    reg_pc_0_o,
    output commit_pkg::inst_t    reg_inst_0_o,
    output logic                 reg_wen_0_o,
    output commit_pkg::reg_num_t reg_wnum_0_o,
    output commit_pkg::data_t    reg_wdata_0_o,
    output logic                 reg_excp_0_o,
    output logic                 reg_ertn_0_o,
    output commit_pkg::ecode_t   reg_ecode_0_o,

    output logic                 reg_valid_1_o,
    output commit_pkg::addr_t    reg_pc_1_o,
    output commit_pkg::inst_t    reg_inst_1_o,
    output logic                 reg_wen_1_o,
    output commit_pkg::reg_num_t reg_wnum_1_o,
    output commit_pkg::data_t    reg_wdata_1_o,
    output logic                 reg_excp_1_o,
    output logic                 reg_ertn_1_o,
    output commit_pkg::ecode_t   reg_ecode_1_o
);

    // single stage, whole commit record cleared on reset
    always_ff @(posedge aclk) begin
        if (rst) begin
            {reg_valid_0_o, reg_wen_0_o, reg_excp_0_o, reg_ertn_0_o} <= '0;
            {reg_pc_0_o, reg_inst_0_o, reg_wnum_0_o, reg_wdata_0_o, reg_ecode_0_o} <= '0;
            {reg_valid_1_o, reg_wen_1_o, reg_excp_1_o, reg_ertn_1_o} <= '0;
            {reg_pc_1_o, reg_inst_1_o, reg_wnum_1_o, reg_wdata_1_o, reg_ecode_1_o} <= '0;
        end else begin
            reg_valid_0_o <= cmt_valid_0_i;
            reg_pc_0_o    <= cmt_pc_0_i;
            reg_inst_0_o  <= cmt_inst_0_i;
            reg_wen_0_o   <= cmt_wen_0_i;
            reg_wnum_0_o  <= cmt_wnum_0_i;
            reg_wdata_0_o <= cmt_wdata_0_i;
            reg_excp_0_o  <= cmt_excp_0_i;
            reg_ertn_0_o  <= cmt_ertn_0_i;
            reg_ecode_0_o <= cmt_ecode_0_i;

            reg_valid_1_o <= cmt_valid_1_i;
            reg_pc_1_o    <= cmt_pc_1_i;
            reg_inst_1_o  <= cmt_inst_1_i;
            reg_wen_1_o   <= cmt_wen_1_i;
            reg_wnum_1_o  <= cmt_wnum_1_i;
            reg_wdata_1_o <= cmt_wdata_1_i;
            reg_excp_1_o  <= cmt_excp_1_i;
            reg_ertn_1_o  <= cmt_ertn_1_i;
            reg_ecode_1_o <= cmt_ecode_1_i;
        end
    end

    // a write-back only exists for a retiring instruction
    a_wen_needs_valid : assert property (@(posedge aclk) disable iff (rst)
        (!reg_wen_0_o || reg_valid_0_o) && (!reg_wen_1_o || reg_valid_1_o));

endmodule

// File: verilog/commit_order.sv
`timescale 1ns/1ps

module commit_order (
    input  logic               aclk,
    input  logic               rst,

    input  logic               valid_0_i,
    input  logic               valid_1_i,
    input  logic               excp_0_i,
    input  logic               excp_1_i,
    input  commit_pkg::addr_t  pc_0_i,
    input  commit_pkg::addr_t  pc_1_i,
    input  commit_pkg::inst_t  inst_0_i,
    input  commit_pkg::inst_t  inst_1_i,
    input  commit_pkg::ecode_t ecode_0_i,
    input  commit_pkg::ecode_t ecode_1_i,

    output logic               slot_o,
    output logic               excp_valid_o,
    output commit_pkg::addr_t  excp_pc_o,
    output commit_pkg::inst_t  excp_inst_o,
    output commit_pkg::ecode_t excp_ecode_o
);

    logic [commit_pkg::NUM_LANES-1:0] valid_vec;
    logic                             lane0_older;
    logic                             sel_lane1;

    assign valid_vec   = {valid_1_i, valid_0_i};
    assign lane0_older = pc_0_i < pc_1_i; // equal pcs count lane 1 as older

    // position of lane 0 among the retiring lanes
    always_comb begin
        case (valid_vec)
            2'b11:   slot_o = !lane0_older;
            2'b10:   slot_o = 1'b1;
            default: slot_o = 1'b0; // lane 0 alone or nothing retiring
        endcase
    end

    // older lane reports if it trapped and the other one otherwise
    always_comb begin
        if (lane0_older) begin
            sel_lane1 = !excp_0_i;
        end else begin
            sel_lane1 = excp_1_i;
        end
    end

    assign excp_valid_o = sel_lane1 ? excp_1_i  : excp_0_i;
    assign excp_pc_o    = sel_lane1 ? pc_1_i    : pc_0_i;
    assign excp_inst_o  = sel_lane1 ? inst_1_i  : inst_0_i;
    assign excp_ecode_o = sel_lane1 ? ecode_1_i : ecode_0_i;

    // a trapped lane always ends up reported
    a_excp_not_lost : assert property (@(posedge aclk) disable iff (rst)
        (excp_0_i || excp_1_i) |-> excp_valid_o);

endmodule

// File: verilog/commit_pkg.sv
package commit_pkg;

    // lane count, fixed at two since the ordering rule compares one pair
    localparam int NUM_LANES = 2;

    localparam int ADDR_W  = 32;
    localparam int INST_W  = 32;
    localparam int DATA_W  = 32;
    localparam int REG_W   = 5;
    localparam int ECODE_W = 6;

    // program counter
    typedef logic [ADDR_W-1:0] addr_t;

    // raw instruction word
    typedef logic [INST_W-1:0] inst_t;

    // register write data
    typedef logic [DATA_W-1:0] data_t;

    // gpr index, 32 entries
    typedef logic [REG_W-1:0] reg_num_t;

    typedef logic [ECODE_W-1:0] ecode_t; // exception cause

endpackage

// File: verilog/commit_trace_top.sv
`timescale 1ns/1ps

module commit_trace_top #(
    parameter int COUNT_W = 64
) (
    input  logic                 aclk,
    input  logic                 rst,

    input  logic                 cmt_valid_0_i,
    input  commit_pkg::addr_t    cmt_pc_0_i,
    input  commit_pkg::inst_t    cmt_inst_0_i,
    input  logic                 cmt_wen_0_i,
    input  commit_pkg::reg_num_t cmt_wnum_0_i,
    input  commit_pkg::data_t    cmt_wdata_0_i,
    input  logic                 cmt_excp_0_i,
    input  logic                 cmt_ertn_0_i,
    input  commit_pkg::ecode_t   cmt_ecode_0_i,

    input  logic                 cmt_valid_1_i,
    input  commit_pkg::addr_t    cmt_pc_1_i,
    input  commit_pkg::inst_t    cmt_inst_1_i,
    input  logic                 cmt_wen_1_i,
    input  commit_pkg::reg_num_t cmt_wnum_1_i,
    input  commit_pkg::data_t    cmt_wdata_1_i,
    input  logic                 cmt_excp_1_i,
    input  logic                 cmt_ertn_1_i,
    input  commit_pkg::ecode_t   cmt_ecode_1_i,

    // per-lane commit trace, one cycle late
    output logic                 trace_valid_0_o,
    output commit_pkg::addr_t    trace_pc_0_o,
    output commit_pkg::inst_t    trace_inst_0_o,
    output logic                 trace_wen_0_o,
    output commit_pkg::reg_num_t trace_wnum_0_o,
    output commit_pkg::data_t    trace_wdata_0_o,

    output logic                 trace_valid_1_o,
    output commit_pkg::addr_t    trace_pc_1_o,
    output commit_pkg::inst_t    trace_inst_1_o,
    output logic                 trace_wen_1_o,
    output commit_pkg::reg_num_t trace_wnum_1_o,
    output commit_pkg::data_t    trace_wdata_1_o,

    output logic                 slot_o,
    output logic                 excp_valid_o,
    output commit_pkg::addr_t    excp_pc_o,
    output commit_pkg::inst_t    excp_inst_o,
    output commit_pkg::ecode_t   excp_ecode_o,
    output logic                 ertn_o,
    output logic [COUNT_W-1:0]   cycle_cnt_o,
    output logic [COUNT_W-1:0]   instr_cnt_o
);

    logic               reg_excp_0;
    logic               reg_excp_1;
    commit_pkg::ecode_t reg_ecode_0;
    commit_pkg::ecode_t reg_ecode_1;

    commit_capture u_capture (
        .aclk          (aclk),
        .rst           (rst),
        .cmt_valid_0_i (cmt_valid_0_i),
        .cmt_pc_0_i    (cmt_pc_0_i),
        .cmt_inst_0_i  (cmt_inst_0_i),
        .cmt_wen_0_i   (cmt_wen_0_i),
        .cmt_wnum_0_i  (cmt_wnum_0_i),
        .cmt_wdata_0_i (cmt_wdata_0_i),
        .cmt_excp_0_i  (cmt_excp_0_i),
        .cmt_ertn_0_i  (cmt_ertn_0_i),
        .cmt_ecode_0_i (cmt_ecode_0_i),
        .cmt_valid_1_i (cmt_valid_1_i),
        .cmt_pc_1_i    (cmt_pc_1_i),
        .cmt_inst_1_i  (cmt_inst_1_i),
        .cmt_wen_1_i   (cmt_wen_1_i),
        .cmt_wnum_1_i  (cmt_wnum_1_i),
        .cmt_wdata_1_i (cmt_wdata_1_i),
        .cmt_excp_1_i  (cmt_excp_1_i),
        .cmt_ertn_1_i  (cmt_ertn_1_i),
        .cmt_ecode_1_i (cmt_ecode_1_i),
        .reg_valid_0_o (trace_valid_0_o),
        .reg_pc_0_o    (trace_pc_0_o),
        .reg_inst_0_o  (trace_inst_0_o),
        .reg_wen_0_o   (trace_wen_0_o),
        .reg_wnum_0_o  (trace_wnum_0_o),
        .reg_wdata_0_o (trace_wdata_0_o),
        .reg_excp_0_o  (reg_excp_0),
        .reg_ertn_0_o  (ertn_o),       // eret event reports lane 0 only
        .reg_ecode_0_o (reg_ecode_0),
        .reg_valid_1_o (trace_valid_1_o),
        .reg_pc_1_o    (trace_pc_1_o),
        .reg_inst_1_o  (trace_inst_1_o),
        .reg_wen_1_o   (trace_wen_1_o),
        .reg_wnum_1_o  (trace_wnum_1_o),
        .reg_wdata_1_o (trace_wdata_1_o),
        .reg_excp_1_o  (reg_excp_1),
        .reg_ertn_1_o  (),
        .reg_ecode_1_o (reg_ecode_1)
    );

    commit_order u_order (
        .aclk         (aclk),
        .rst          (rst),
        .valid_0_i    (trace_valid_0_o),
        .valid_1_i    (trace_valid_1_o),
        .excp_0_i     (reg_excp_0),
        .excp_1_i     (reg_excp_1),
        .pc_0_i       (trace_pc_0_o),
        .pc_1_i       (trace_pc_1_o),
        .inst_0_i     (trace_inst_0_o),
        .inst_1_i     (trace_inst_1_o),
        .ecode_0_i    (reg_ecode_0),
        .ecode_1_i    (reg_ecode_1),
        .slot_o       (slot_o),
        .excp_valid_o (excp_valid_o),
        .excp_pc_o    (excp_pc_o),
        .excp_inst_o  (excp_inst_o),
        .excp_ecode_o (excp_ecode_o)
    );

    event_counters #(
        .COUNT_W (COUNT_W)
    ) u_counters (
        .aclk        (aclk),
        .rst         (rst),
        .valid_0_i   (trace_valid_0_o),
        .valid_1_i   (trace_valid_1_o),
        .cycle_cnt_o (cycle_cnt_o),
        .instr_cnt_o (instr_cnt_o)
    );

endmodule

// File: verilog/event_counters.sv
`timescale 1ns/1ps

module event_counters #(
    parameter int COUNT_W = 64
) (
    input  logic               aclk,
    input  logic               rst,
    input  logic               valid_0_i,
    input  logic               valid_1_i,
    output logic [COUNT_W-1:0] cycle_cnt_o,
    output logic [COUNT_W-1:0] instr_cnt_o
);

    logic [commit_pkg::NUM_LANES-1:0] valid_vec;
    logic [COUNT_W-1:0]               lanes_retired;

    assign valid_vec     = {valid_1_i, valid_0_i};
    assign lanes_retired = COUNT_W'($countones(valid_vec)); // 0, 1 or 2

    always_ff @(posedge aclk) begin
        if (rst) begin
            cycle_cnt_o <= '0;
            instr_cnt_o <= '0;
        end else begin
            cycle_cnt_o <= cycle_cnt_o + COUNT_W'(1);
            instr_cnt_o <= instr_cnt_o + lanes_retired;
        end
    end

    // at most one retirement per lane per cycle, wrap included
    a_instr_step : assert property (@(posedge aclk) disable iff (rst)
        !$past(rst) |-> (COUNT_W'(instr_cnt_o - $past(instr_cnt_o)) <= COUNT_W'(2)));

endmodule
